// ==== bench/tb_clock.sv ====
//==============================
// testbench clock and reset
//==============================
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period_ns = 100
) (
    input  logic restart,
    output logic clk,
    output logic rst_n
);

    int hold;

    initial
    begin
        clk   = 1'b0;
        rst_n = 1'b0;
        hold  = 1;
    end

    always #(period_ns / 2) clk = ~clk;

    // reset stays low for two rising edges after a restart request
    always @(posedge clk)
    begin
        if (restart)
        begin
            rst_n <= 1'b0;
            hold  <= 1;
        end
        else if (hold > 0)
            hold <= hold - 1;
        else
            rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/tb_cpu.sv ====
//==============================
// testbench for cpu_core: runs
// programs against an ISA model
//==============================
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    localparam int clk_period_ns   = 100;
    localparam int addr_bits       = 6;
    localparam int mem_words       = 1 << addr_bits;
    localparam int run_cycles      = 400;
    localparam int random_programs = 4;
    localparam int num_tests       = 5 + random_programs;

    logic               clk;
    logic               rst_n;
    logic               restart = 1'b0;
    cpu_pkg::pc_t       inst_addr;
    cpu_pkg::word_t     instruction;
    cpu_pkg::word_t     data_addr;
    cpu_pkg::word_t     data_write;
    logic               data_wen;
    cpu_pkg::word_t     data_read;

    cpu_pkg::word_t     imem  [mem_words];
    cpu_pkg::word_t     dmem  [mem_words];
    cpu_pkg::word_t     prog  [mem_words];
    cpu_pkg::word_t     dinit [mem_words];
    int                 prog_len;
    cpu_pkg::word_t     exp_addr [$];
    cpu_pkg::word_t     exp_data [$];
    int                 store_idx;
    int                 test_errors;
    int                 tests_run;
    int                 tests_failed;
    string              cur_test;

    tb_clock #(.period_ns(clk_period_ns)) u_clock (
        .restart(restart), .clk(clk), .rst_n(rst_n)
    );

    cpu_core uut (
        .clk(clk), .rst_n(rst_n), .inst_addr(inst_addr), .instruction(instruction),
        .data_addr(data_addr), .data_write(data_write), .data_wen(data_wen),
        .data_read(data_read)
    );

    assign instruction = imem[inst_addr[addr_bits-1:0]];
    assign data_read   = dmem[data_addr[addr_bits-1:0]];

    always @(posedge clk)
    begin
        if (data_wen)
            dmem[data_addr[addr_bits-1:0]] <= data_write;
    end

    task automatic check(input string what, input cpu_pkg::word_t expected,
                         input cpu_pkg::word_t actual);
        if (expected !== actual)
        begin
            $display("** Error %s %s: expected %h, actual %h", cur_test, what, expected, actual);
            test_errors++;
        end
    endtask

    // every slot holds jump-to-self until overwritten
    task automatic clear_program();
        for (int i = 0; i < mem_words; i++)
        begin
            prog[i]  = {cpu_pkg::op_j, 26'(i)};
            dinit[i] = 32'h5a5a_0000 + i * 32'h0001_0203;
        end
        prog_len = 0;
    endtask

    task automatic emit_r(input cpu_pkg::funct_t fn, input cpu_pkg::reg_addr_t rd,
                          input cpu_pkg::reg_addr_t rs, input cpu_pkg::reg_addr_t rt);
        prog[prog_len] = {cpu_pkg::op_rtype, rs, rt, rd, 5'd0, fn};
        prog_len++;
    endtask

    task automatic emit_i(input cpu_pkg::opcode_t op, input cpu_pkg::reg_addr_t rt,
                          input cpu_pkg::reg_addr_t rs, input logic [15:0] imm);
        prog[prog_len] = {op, rs, rt, imm};
        prog_len++;
    endtask

    task automatic emit_j(input logic [25:0] target);
        prog[prog_len] = {cpu_pkg::op_j, target};
        prog_len++;
    endtask

    // ISA-level interpreter that records stores in program order
    function automatic void run_reference();
        cpu_pkg::word_t     regs [32];
        cpu_pkg::word_t     mem  [mem_words];
        cpu_pkg::word_t     inst, a, b, imm, ea;
        cpu_pkg::pc_t       pc, next;
        cpu_pkg::reg_addr_t rs, rt, rd;
        int                 steps;
        logic               halted;
        exp_addr.delete();
        exp_data.delete();
        foreach (regs[i])
            regs[i] = '0;
        foreach (mem[i])
            mem[i] = dinit[i];
        pc     = '0;
        steps  = 0;
        halted = 1'b0;
        while (steps < 300 && !halted)
        begin
            inst = prog[pc[addr_bits-1:0]];
            rs   = inst[25:21];
            rt   = inst[20:16];
            rd   = inst[15:11];
            imm  = {{16{inst[15]}}, inst[15:0]};
            a    = regs[rs];
            b    = regs[rt];
            ea   = a + imm;
            next = pc + 1;
            case (inst[31:26])
                cpu_pkg::op_rtype:
                begin
                    if (inst[5:0] == cpu_pkg::fn_add)
                        regs[rd] = a + b;
                    else if (inst[5:0] == cpu_pkg::fn_slt)
                        regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                end
                cpu_pkg::op_addi: regs[rt] = ea;
                cpu_pkg::op_lw:   regs[rt] = mem[ea[addr_bits-1:0]];
                cpu_pkg::op_sw:
                begin
                    exp_addr.push_back(ea);
                    exp_data.push_back(b);
                    mem[ea[addr_bits-1:0]] = b;
                end
                cpu_pkg::op_beq:
                begin
                    if (a == b)
                        next = pc + 1 + imm;
                end
                cpu_pkg::op_j:
                begin
                    next   = {next[31:26], inst[25:0]};
                    halted = (next == pc);
                end
                default:
                begin
                end
            endcase
            regs[0] = '0;
            pc      = next;
            steps++;
        end
    endfunction

    always @(posedge clk)
    begin
        if (rst_n && data_wen)
        begin
            if (store_idx < exp_addr.size())
            begin
                check("store address", exp_addr[store_idx], data_addr);
                check("store data", exp_data[store_idx], data_write);
            end
            else
            begin
                $display("%s: unexpected store to %h, only %0d stores expected",
                         cur_test, data_addr, exp_addr.size());
                test_errors++;
            end
            store_idx++;
        end
    end

    task automatic run_test(input string name);
        @(posedge clk);
        restart <= 1'b1;
        @(posedge clk);
        restart <= 1'b0;
        wait (rst_n == 1'b0);
        cur_test = name;
        for (int i = 0; i < mem_words; i++)
        begin
            imem[i] = prog[i];
            dmem[i] = dinit[i];
        end
        run_reference();
        store_idx   = 0;
        test_errors = 0;
        wait (rst_n == 1'b1);
        // fetch starts at address 0 with no store pending
        @(negedge clk);
        check("reset pc", '0, inst_addr);
        check("reset store enable", '0, {31'b0, data_wen});
        repeat (run_cycles) @(posedge clk);
        @(negedge clk);
        if (store_idx != exp_addr.size())
        begin
            $display("%s: %0d stores seen but %0d expected", name, store_idx, exp_addr.size());
            test_errors++;
        end
        $display("%-10s %s, %0d stores, %0d errors", name,
                 (test_errors == 0) ? "ok" : "failed", store_idx, test_errors);
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
    endtask

    initial
    begin
        #(num_tests * 500 * clk_period_ns);
        $display("timeout: tests did not finish within %0d cycles", num_tests * 500);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        void'($urandom(32'hfc8c));
        tests_run    = 0;
        tests_failed = 0;
        clear_program();
        foreach (imem[i])
        begin
            imem[i] = prog[i];
            dmem[i] = dinit[i];
        end

        // arithmetic with a negative operand
        emit_i(cpu_pkg::op_addi, 1, 0, 7);
        emit_i(cpu_pkg::op_addi, 2, 0, -3);
        emit_r(cpu_pkg::fn_add, 3, 1, 2);
        emit_r(cpu_pkg::fn_slt, 4, 2, 1);
        emit_r(cpu_pkg::fn_slt, 5, 1, 2);
        emit_i(cpu_pkg::op_sw, 3, 0, 0);
        emit_i(cpu_pkg::op_sw, 4, 0, 1);
        emit_i(cpu_pkg::op_sw, 5, 0, 2);
        emit_i(cpu_pkg::op_sw, 2, 0, 3);
        run_test("arith");

        // dependent chains back to back and one apart plus dropped r0 writes
        clear_program();
        emit_i(cpu_pkg::op_addi, 1, 0, 1);
        emit_r(cpu_pkg::fn_add, 2, 1, 1);
        emit_r(cpu_pkg::fn_add, 3, 2, 1);
        emit_i(cpu_pkg::op_sw, 3, 0, 4);
        emit_i(cpu_pkg::op_addi, 0, 0, 9);
        emit_r(cpu_pkg::fn_add, 4, 0, 3);
        emit_i(cpu_pkg::op_addi, 6, 0, 2);
        emit_r(cpu_pkg::fn_add, 5, 4, 2);
        emit_i(cpu_pkg::op_sw, 4, 0, 5);
        emit_i(cpu_pkg::op_sw, 5, 0, 6);
        emit_i(cpu_pkg::op_sw, 0, 0, 7);
        run_test("forwarding");

        clear_program();
        emit_i(cpu_pkg::op_lw, 1, 0, 10);
        emit_r(cpu_pkg::fn_add, 2, 1, 1);
        emit_i(cpu_pkg::op_sw, 2, 0, 11);
        emit_i(cpu_pkg::op_lw, 3, 0, 12);
        emit_i(cpu_pkg::op_lw, 4, 0, 13);
        emit_r(cpu_pkg::fn_add, 5, 3, 4);
        emit_i(cpu_pkg::op_sw, 5, 0, 14);
        run_test("load_use");

        // five-pass loop closed by a backward beq at address 8
        clear_program();
        emit_i(cpu_pkg::op_addi, 1, 0, 0);
        emit_i(cpu_pkg::op_addi, 5, 0, 5);
        emit_i(cpu_pkg::op_addi, 6, 0, 1);
        emit_i(cpu_pkg::op_addi, 2, 0, 100);
        emit_i(cpu_pkg::op_addi, 1, 1, 1);
        emit_r(cpu_pkg::fn_add, 2, 2, 1);
        emit_i(cpu_pkg::op_sw, 2, 1, 20);
        emit_r(cpu_pkg::fn_slt, 4, 1, 5);
        emit_i(cpu_pkg::op_beq, 6, 4, -5);
        emit_i(cpu_pkg::op_sw, 1, 0, 30);
        emit_i(cpu_pkg::op_beq, 0, 1, 1);
        emit_i(cpu_pkg::op_sw, 2, 0, 31);
        run_test("branch");

        clear_program();
        emit_i(cpu_pkg::op_addi, 1, 0, 11);
        emit_j(4);
        emit_i(cpu_pkg::op_sw, 1, 0, 40);
        emit_i(cpu_pkg::op_sw, 1, 0, 41);
        emit_i(cpu_pkg::op_sw, 1, 0, 42);
        emit_i(cpu_pkg::op_addi, 1, 1, 1);
        emit_i(cpu_pkg::op_sw, 1, 0, 43);
        run_test("jump");

        for (int k = 0; k < random_programs; k++)
        begin
            clear_program();
            foreach (dinit[i])
                dinit[i] = $urandom();
            for (int n = 0; n < 20; n++)
            begin
                case ($urandom_range(4, 0))
                    0: emit_i(cpu_pkg::op_addi, $urandom_range(4, 0), $urandom_range(4, 0),
                              $urandom());
                    1: emit_r(cpu_pkg::fn_add, $urandom_range(4, 0), $urandom_range(4, 0),
                              $urandom_range(4, 0));
                    2: emit_r(cpu_pkg::fn_slt, $urandom_range(4, 0), $urandom_range(4, 0),
                              $urandom_range(4, 0));
                    3: emit_i(cpu_pkg::op_lw, $urandom_range(4, 0), 0, $urandom_range(7, 0));
                    default: emit_i(cpu_pkg::op_sw, $urandom_range(4, 0), 0,
                                    $urandom_range(7, 0));
                endcase
            end
            for (int r = 1; r < 5; r++)
                emit_i(cpu_pkg::op_sw, r, 0, 8 + r);
            run_test($sformatf("random_%0d", k));
        end

        $display("%0d tests run, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/cpu_btb.sv ====
//==============================
// branch target buffer, fully
// associative, hit means taken
//==============================
`timescale 1ns/1ps
`default_nettype none

module cpu_btb #(
    parameter int btb_entries = 4
) (
    input  logic         clk,
    input  logic         rst_n,
    input  cpu_pkg::pc_t fetch_pc,
    input  logic         alloc,
    input  logic         invalidate,
    input  cpu_pkg::pc_t branch_pc,
    input  cpu_pkg::pc_t branch_target,
    output logic         hit,
    output cpu_pkg::pc_t hit_target
);

    cpu_pkg::pc_t           tags    [btb_entries];
    cpu_pkg::pc_t           targets [btb_entries];
    logic [btb_entries-1:0] valid;
    logic [btb_entries-1:0] tag_match;
    logic [btb_entries-1:0] lookup_hit;
    logic                   have_free;
    logic                   do_alloc;
    int                     alloc_idx;

    always_comb
    begin
        have_free = 1'b0;
        alloc_idx = 0;
        for (int i = 0; i < btb_entries; i++)
        begin
            tag_match[i]  = valid[i] && (tags[i] == branch_pc);
            lookup_hit[i] = valid[i] && (tags[i] == fetch_pc);
            // last free slot seen is the highest one
            if (!valid[i])
            begin
                have_free = 1'b1;
                alloc_idx = i;
            end
        end
    end

    // no allocation when full or already present
    assign do_alloc = alloc && have_free && !(|tag_match);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            valid <= '0;
        else if (do_alloc)
            valid[alloc_idx] <= 1'b1;
        else if (invalidate)
            valid <= valid & ~tag_match;
    end

    always_ff @(posedge clk)
    begin
        if (do_alloc)
        begin
            tags[alloc_idx]    <= branch_pc;
            targets[alloc_idx] <= branch_target;
        end
    end

    always_comb
    begin
        hit_target = '0;
        for (int i = 0; i < btb_entries; i++)
        begin
            if (lookup_hit[i])
                hit_target = targets[i];
        end
    end

    assign hit = |lookup_hit;

    for (genvar i = 0; i < btb_entries; i++)
    begin : g_tag_i
        for (genvar j = i + 1; j < btb_entries; j++)
        begin : g_tag_j
            a_unique_tag: assert property (@(posedge clk) disable iff (!rst_n)
                !(valid[i] && valid[j] && tags[i] == tags[j]))
                else $error("btb entries %0d and %0d share a tag", i, j);
        end
    end

endmodule

`default_nettype wire

// ==== hw/cpu_core.sv ====
//==============================
// cpu core: five-stage pipeline
// with forwarding and a BTB
//==============================
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
    parameter int btb_entries = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    output cpu_pkg::pc_t   inst_addr,
    input  cpu_pkg::word_t instruction,
    output cpu_pkg::word_t data_addr,
    output cpu_pkg::word_t data_write,
    output logic           data_wen,
    input  cpu_pkg::word_t data_read
);

    cpu_pkg::pc_t       pc_if, pc_plus_1_if, next_pc, btb_target;
    logic               btb_hit;
    cpu_pkg::word_t     inst_id;
    cpu_pkg::pc_t       pc_id, pc_plus_1_id, branch_target_id, jump_target_id;
    logic               predicted_id;
    cpu_pkg::reg_addr_t rs_id, rt_id, rd_id;
    cpu_pkg::word_t     imm_id, rs_val_id, rt_val_id;
    logic               reg_dst_id, jump_id, branch_id, mem_to_reg_id, mem_write_id;
    logic               mem_read_id, alu_src_id, reg_write_id, uses_rs_id, uses_rt_id;
    cpu_pkg::alu_op_t   alu_op_id;
    logic               stall;
    cpu_pkg::fwd_sel_t  fwd_a, fwd_b;
    logic               reg_dst_ex, branch_ex, mem_to_reg_ex, mem_write_ex;
    logic               mem_read_ex, alu_src_ex, reg_write_ex, predicted_ex;
    cpu_pkg::alu_op_t   alu_op_ex;
    cpu_pkg::word_t     rs_val_ex, rt_val_ex, imm_ex, alu_result_ex, store_data_ex;
    cpu_pkg::reg_addr_t rs_ex, rt_ex, rd_ex, dest_ex;
    cpu_pkg::pc_t       pc_ex, pc_plus_1_ex, branch_target_ex, recover_pc;
    logic               mispredict;
    logic               mem_to_reg_mem, mem_write_mem, reg_write_mem;
    cpu_pkg::word_t     alu_result_mem, store_data_mem;
    cpu_pkg::reg_addr_t rd_mem;
    logic               mem_to_reg_wb, reg_write_wb;
    cpu_pkg::word_t     alu_result_wb, read_data_wb, result_wb;
    cpu_pkg::reg_addr_t rd_wb;

    // recovery has priority over jump and BTB for the next PC
    assign inst_addr    = pc_if;
    assign pc_plus_1_if = pc_if + 32'd1;
    assign next_pc = mispredict ? recover_pc :
                     jump_id    ? jump_target_id :
                     btb_hit    ? btb_target : pc_plus_1_if;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pc_if <= '0;
        else if (mispredict || !stall)
            pc_if <= next_pc;
    end

    cpu_btb #(.btb_entries(btb_entries)) u_btb (
        .clk(clk), .rst_n(rst_n), .fetch_pc(pc_if),
        .alloc(mispredict && !predicted_ex), .invalidate(mispredict && predicted_ex),
        .branch_pc(pc_ex), .branch_target(branch_target_ex),
        .hit(btb_hit), .hit_target(btb_target)
    );

    // IF/ID is squashed by a jump in ID or a mispredict
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            inst_id      <= '0;
            predicted_id <= 1'b0;
        end
        else if (jump_id || mispredict)
        begin
            inst_id      <= '0;
            predicted_id <= 1'b0;
        end
        else if (!stall)
        begin
            inst_id      <= instruction;
            predicted_id <= btb_hit;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            pc_id        <= pc_if;
            pc_plus_1_id <= pc_plus_1_if;
        end
    end

    assign rs_id            = inst_id[25:21];
    assign rt_id            = inst_id[20:16];
    assign rd_id            = inst_id[15:11];
    assign imm_id           = {{16{inst_id[15]}}, inst_id[15:0]};
    assign branch_target_id = pc_plus_1_id + imm_id;
    assign jump_target_id   = {pc_plus_1_id[31:26], inst_id[25:0]};

    cpu_decoder u_decoder (
        .opcode(inst_id[31:26]), .funct(inst_id[5:0]),
        .reg_dst(reg_dst_id), .jump(jump_id), .branch(branch_id),
        .mem_to_reg(mem_to_reg_id), .mem_write(mem_write_id), .mem_read(mem_read_id),
        .alu_src(alu_src_id), .reg_write(reg_write_id),
        .uses_rs(uses_rs_id), .uses_rt(uses_rt_id), .alu_op(alu_op_id)
    );

    cpu_regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .rs_addr(rs_id), .rt_addr(rt_id),
        .wr_addr(rd_wb), .wr_en(reg_write_wb), .wr_data(result_wb),
        .rs_data(rs_val_id), .rt_data(rt_val_id)
    );

    cpu_hazard_unit u_hazard (
        .rs_id(rs_id), .rt_id(rt_id), .rs_ex(rs_ex), .rt_ex(rt_ex),
        .rt_ex_load(dest_ex), .rd_mem(rd_mem), .rd_wb(rd_wb),
        .uses_rs(uses_rs_id), .uses_rt(uses_rt_id), .mem_read_ex(mem_read_ex),
        .reg_write_mem(reg_write_mem), .reg_write_wb(reg_write_wb),
        .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    // ID/EX takes a bubble on stall or mispredict
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n || stall || mispredict)
        begin
            {reg_dst_ex, branch_ex, mem_to_reg_ex, mem_write_ex} <= '0;
            {mem_read_ex, alu_src_ex, reg_write_ex, predicted_ex} <= '0;
            alu_op_ex <= cpu_pkg::alu_add;
        end
        else
        begin
            {reg_dst_ex, branch_ex, mem_to_reg_ex, mem_write_ex} <=
                {reg_dst_id, branch_id, mem_to_reg_id, mem_write_id};
            {mem_read_ex, alu_src_ex, reg_write_ex, predicted_ex} <=
                {mem_read_id, alu_src_id, reg_write_id, predicted_id};
            alu_op_ex <= alu_op_id;
        end
    end

    always_ff @(posedge clk)
    begin
        {rs_val_ex, rt_val_ex, imm_ex} <= {rs_val_id, rt_val_id, imm_id};
        {rs_ex, rt_ex, rd_ex}          <= {rs_id, rt_id, rd_id};
        {pc_ex, pc_plus_1_ex}          <= {pc_id, pc_plus_1_id};
        branch_target_ex               <= branch_target_id;
    end

    assign dest_ex = reg_dst_ex ? rd_ex : rt_ex;

    cpu_execute u_execute (
        .alu_op(alu_op_ex), .alu_src(alu_src_ex), .branch(branch_ex),
        .predicted(predicted_ex), .rs_val(rs_val_ex), .rt_val(rt_val_ex), .imm(imm_ex),
        .mem_result(alu_result_mem), .wb_result(result_wb), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .pc_plus_1(pc_plus_1_ex), .branch_target(branch_target_ex),
        .alu_result(alu_result_ex), .store_data(store_data_ex),
        .mispredict(mispredict), .recover_pc(recover_pc)
    );

    // EX/MEM and MEM/WB control
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            {mem_to_reg_mem, mem_write_mem, reg_write_mem} <= '0;
            {mem_to_reg_wb, reg_write_wb} <= '0;
        end
        else
        begin
            {mem_to_reg_mem, mem_write_mem, reg_write_mem} <=
                {mem_to_reg_ex, mem_write_ex, reg_write_ex};
            {mem_to_reg_wb, reg_write_wb} <= {mem_to_reg_mem, reg_write_mem};
        end
    end

    always_ff @(posedge clk)
    begin
        alu_result_mem <= alu_result_ex;
        store_data_mem <= store_data_ex;
        rd_mem         <= dest_ex;
        alu_result_wb  <= alu_result_mem;
        read_data_wb   <= data_read;
        rd_wb          <= rd_mem;
    end

    assign data_addr  = alu_result_mem;
    assign data_write = store_data_mem;
    assign data_wen   = mem_write_mem;
    assign result_wb  = mem_to_reg_wb ? read_data_wb : alu_result_wb;

endmodule

`default_nettype wire

// ==== hw/cpu_decoder.sv ====
//==============================
// decoder: opcode and funct to
// pipeline control levels
//==============================
`timescale 1ns/1ps
`default_nettype none

module cpu_decoder (
    input  cpu_pkg::opcode_t opcode,
    input  cpu_pkg::funct_t  funct,
    output logic             reg_dst,
    output logic             jump,
    output logic             branch,
    output logic             mem_to_reg,
    output logic             mem_write,
    output logic             mem_read,
    output logic             alu_src,
    output logic             reg_write,
    output logic             uses_rs,
    output logic             uses_rt,
    output cpu_pkg::alu_op_t alu_op
);

    always_comb
    begin
        // unknown encodings fall out as a no-op
        reg_dst    = 1'b0;
        jump       = 1'b0;
        branch     = 1'b0;
        mem_to_reg = 1'b0;
        mem_write  = 1'b0;
        mem_read   = 1'b0;
        alu_src    = 1'b0;
        reg_write  = 1'b0;
        uses_rs    = 1'b0;
        uses_rt    = 1'b0;
        alu_op     = cpu_pkg::alu_add;
        case (opcode)
            cpu_pkg::op_rtype:
            begin
                if (funct == cpu_pkg::fn_add || funct == cpu_pkg::fn_slt)
                begin
                    reg_dst   = 1'b1;
                    reg_write = 1'b1;
                    uses_rs   = 1'b1;
                    uses_rt   = 1'b1;
                    alu_op    = (funct == cpu_pkg::fn_slt) ? cpu_pkg::alu_slt : cpu_pkg::alu_add;
                end
            end
            cpu_pkg::op_addi:
            begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
                uses_rs   = 1'b1;
            end
            cpu_pkg::op_beq:
            begin
                branch  = 1'b1;
                alu_op  = cpu_pkg::alu_sub;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
            end
            cpu_pkg::op_j:
            begin
                jump = 1'b1;
            end
            cpu_pkg::op_lw:
            begin
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                alu_src    = 1'b1;
                reg_write  = 1'b1;
                uses_rs    = 1'b1;
            end
            cpu_pkg::op_sw:
            begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
            end
            default:
            begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/cpu_execute.sv ====
//==============================
// execute: forwarding muxes, ALU
// and branch resolution
//==============================
`timescale 1ns/1ps
`default_nettype none

module cpu_execute (
    input  cpu_pkg::alu_op_t  alu_op,
    input  logic              alu_src,
    input  logic              branch,
    input  logic              predicted,
    input  cpu_pkg::word_t    rs_val,
    input  cpu_pkg::word_t    rt_val,
    input  cpu_pkg::word_t    imm,
    input  cpu_pkg::word_t    mem_result,
    input  cpu_pkg::word_t    wb_result,
    input  cpu_pkg::fwd_sel_t fwd_a,
    input  cpu_pkg::fwd_sel_t fwd_b,
    input  cpu_pkg::pc_t      pc_plus_1,
    input  cpu_pkg::pc_t      branch_target,
    output cpu_pkg::word_t    alu_result,
    output cpu_pkg::word_t    store_data,
    output logic              mispredict,
    output cpu_pkg::pc_t      recover_pc
);

    cpu_pkg::word_t op_a;
    cpu_pkg::word_t op_b_reg;
    cpu_pkg::word_t op_b;
    logic           taken;

    function automatic cpu_pkg::word_t fwd_mux(input cpu_pkg::fwd_sel_t sel,
                                               input cpu_pkg::word_t reg_val);
        case (sel)
            cpu_pkg::fwd_mem: return mem_result;
            cpu_pkg::fwd_wb:  return wb_result;
            default:          return reg_val;
        endcase
    endfunction

    always_comb
    begin
        op_a     = fwd_mux(fwd_a, rs_val);
        op_b_reg = fwd_mux(fwd_b, rt_val);
        op_b     = alu_src ? imm : op_b_reg;
        case (alu_op)
            cpu_pkg::alu_add: alu_result = op_a + op_b;
            cpu_pkg::alu_sub: alu_result = op_a - op_b;
            cpu_pkg::alu_slt: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            default:          alu_result = '0;
        endcase
    end

    // sw stores the forwarded rt, not the immediate path
    assign store_data = op_b_reg;

    // beq is taken on equal operands
    assign taken      = branch && (alu_result == '0);
    assign mispredict = (taken != predicted);
    assign recover_pc = (mispredict && taken) ? branch_target : pc_plus_1;

    a_mispredict_is_branch: assert final (branch || !mispredict)
        else $error("mispredict raised for a non-branch");

endmodule

`default_nettype wire

// ==== hw/cpu_hazard_unit.sv ====
//==============================
// hazard unit: load-use stall
// and EX operand forwarding
//==============================
`timescale 1ns/1ps
`default_nettype none

module cpu_hazard_unit (
    input  cpu_pkg::reg_addr_t rs_id,
    input  cpu_pkg::reg_addr_t rt_id,
    input  cpu_pkg::reg_addr_t rs_ex,
    input  cpu_pkg::reg_addr_t rt_ex,
    input  cpu_pkg::reg_addr_t rt_ex_load,
    input  cpu_pkg::reg_addr_t rd_mem,
    input  cpu_pkg::reg_addr_t rd_wb,
    input  logic               uses_rs,
    input  logic               uses_rt,
    input  logic               mem_read_ex,
    input  logic               reg_write_mem,
    input  logic               reg_write_wb,
    output logic               stall,
    output cpu_pkg::fwd_sel_t  fwd_a,
    output cpu_pkg::fwd_sel_t  fwd_b
);

    // newest producer wins
    function automatic cpu_pkg::fwd_sel_t pick_source(input cpu_pkg::reg_addr_t src);
        if (reg_write_mem && rd_mem != '0 && rd_mem == src)
            return cpu_pkg::fwd_mem;
        if (reg_write_wb && rd_wb != '0 && rd_wb == src)
            return cpu_pkg::fwd_wb;
        return cpu_pkg::fwd_none;
    endfunction

    always_comb
    begin
        fwd_a = pick_source(rs_ex);
        fwd_b = pick_source(rt_ex);
    end

    // only real source reads count, so j never stalls
    assign stall = mem_read_ex && (rt_ex_load != '0)
                   && ((uses_rs && rs_id == rt_ex_load) || (uses_rt && rt_id == rt_ex_load));

    a_fwd_mem_needs_write: assert final (reg_write_mem
        || (fwd_a != cpu_pkg::fwd_mem && fwd_b != cpu_pkg::fwd_mem))
        else $error("forwarding from MEM without a register write");

endmodule

`default_nettype wire

// ==== hw/cpu_pkg.sv ====
//==============================
// cpu package: widths, opcodes,
// ALU and forwarding codes
//==============================
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] pc_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [1:0]  alu_op_t;
    typedef logic [1:0]  fwd_sel_t;

    localparam opcode_t op_rtype = 6'b000000;
    localparam opcode_t op_addi  = 6'b001000;
    localparam opcode_t op_beq   = 6'b000100;
    localparam opcode_t op_j     = 6'b000010;
    localparam opcode_t op_lw    = 6'b100011;
    localparam opcode_t op_sw    = 6'b101011;

    localparam funct_t fn_add = 6'b100000;
    localparam funct_t fn_slt = 6'b101010;

    localparam alu_op_t alu_add = 2'b00;
    localparam alu_op_t alu_sub = 2'b01;
    localparam alu_op_t alu_slt = 2'b10;

    // operand source in EX
    localparam fwd_sel_t fwd_none = 2'b00;
    localparam fwd_sel_t fwd_wb   = 2'b01;
    localparam fwd_sel_t fwd_mem  = 2'b10;

endpackage

`default_nettype wire

// ==== hw/cpu_regfile.sv ====
//==============================
// register file: 32 x 32 with
// r0 at zero and write-through
//==============================
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    input  cpu_pkg::reg_addr_t wr_addr,
    input  logic               wr_en,
    input  cpu_pkg::word_t     wr_data,
    output cpu_pkg::word_t     rs_data,
    output cpu_pkg::word_t     rt_data
);

    cpu_pkg::word_t regs [32];
    logic           wr_live;

    // r0 is never written, so it stays at its reset value
    assign wr_live = wr_en && (wr_addr != '0);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr_live)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // same-cycle write is visible to ID
    assign rs_data = (wr_live && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_data = (wr_live && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

    a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs_addr != '0 || rs_data == '0) && (rt_addr != '0 || rt_data == '0))
        else $error("r0 read back nonzero");

endmodule

`default_nettype wire

// ==== src.f ====
hw/cpu_pkg.sv
hw/cpu_decoder.sv
hw/cpu_regfile.sv
hw/cpu_hazard_unit.sv
hw/cpu_execute.sv
hw/cpu_btb.sv
hw/cpu_core.sv
bench/tb_clock.sv
bench/tb_cpu.sv
